// File: source/rp_cfg.svh
// system configuration constants
`ifndef RP_CFG_SVH
`define RP_CFG_SVH

// data path and bus widths
`define RP_ADC_BITS     14            // converter word
`define RP_BUS_BITS     32            // bus address and data
`define RP_SEL_BITS     4             // byte lanes
`define RP_LED_BITS     8

// region field of the bus address
`define RP_REGIONS      8
`define RP_REGION_MSB   22
`define RP_REGION_LSB   20

// region numbers
`define RP_REG_HK       3'd0          // housekeeping
`define RP_REG_ADC      3'd1          // adc readback
`define RP_REG_DAC      3'd3          // dac levels

// offsets inside a region, addr[19:0]
`define RP_HK_ID_OFS    20'h00000
`define RP_HK_LOOP_OFS  20'h00004
`define RP_HK_LED_OFS   20'h00030
`define RP_ADC_A_OFS    20'h00000
`define RP_ADC_B_OFS    20'h00004
`define RP_DAC_A_OFS    20'h00000
`define RP_DAC_B_OFS    20'h00004

// board identification word
`define RP_HK_ID        32'h5250_0001

`endif

// File: source/rp_pkg.sv
// shared data path types
`default_nettype none

`include "rp_cfg.svh"

package rp_pkg;

  ////////////////////////////////////////////////////////////
  // converter words
  ////////////////////////////////////////////////////////////

  // pin format, negative slope offset binary
  typedef logic        [`RP_ADC_BITS-1:0] adc_raw_t;
  // internal sample, two's complement
  typedef logic signed [`RP_ADC_BITS-1:0] sample_t;

  ////////////////////////////////////////////////////////////
  // system bus
  ////////////////////////////////////////////////////////////

  typedef logic [`RP_BUS_BITS-1:0]      bus_addr_t;
  typedef logic [`RP_BUS_BITS-1:0]      bus_data_t;
  typedef logic [`RP_SEL_BITS-1:0]      bus_sel_t;   // byte enables
  typedef logic [$clog2(`RP_REGIONS)-1:0] region_t;  // addr[22:20]

  // board io
  typedef logic [`RP_LED_BITS-1:0]      led_t;

endpackage

`default_nettype wire

// File: source/sys_bus_if.sv
// single region bus link
`timescale 1ns/1ps
`default_nettype none

interface sys_bus_if;

  // request, valid in the strobe cycle
  rp_pkg::bus_addr_t addr;
  rp_pkg::bus_data_t wdata;
  rp_pkg::bus_sel_t  sel;
  logic              wen;    // one cycle write strobe
  logic              ren;    // one cycle read strobe

  // response, one cycle after the strobe
  rp_pkg::bus_data_t rdata;  // zero on writes
  logic              ack;

  // decoder side
  modport master (
    output addr, wdata, sel, wen, ren,
    input  rdata, ack
  );

  // region slave side
  modport slave (
    input  addr, wdata, sel, wen, ren,
    output rdata, ack
  );

endinterface

`default_nettype wire

// File: source/sys_bus_decode.sv
// bus region decoder and response mux
`timescale 1ns/1ps
`default_nettype none

`include "rp_cfg.svh"

module sys_bus_decode (
  input  wire               adc_clk,
  input  wire               arst_n_i,
  input  rp_pkg::bus_addr_t sys_addr_i,
  input  rp_pkg::bus_data_t sys_wdata_i,
  input  rp_pkg::bus_sel_t  sys_sel_i,
  input  wire               sys_wen_i,
  input  wire               sys_ren_i,
  output rp_pkg::bus_data_t sys_rdata_o,
  output logic              sys_ack_o,
  sys_bus_if.master         hk_bus,
  sys_bus_if.master         adc_bus,
  sys_bus_if.master         dac_bus
);

  rp_pkg::region_t req_region;   // region of the current request
  rp_pkg::region_t rsp_region;   // region of the last request
  logic            strobe;
  logic            unmapped;
  logic            def_ack;      // local responder for empty regions

  assign req_region = sys_addr_i[`RP_REGION_MSB:`RP_REGION_LSB];
  assign strobe     = sys_wen_i || sys_ren_i;
  assign unmapped   = (req_region != `RP_REG_HK) && (req_region != `RP_REG_ADC) &&
                      (req_region != `RP_REG_DAC);

  ////////////////////////////////////////////////////////////
  // request fan out
  ////////////////////////////////////////////////////////////

  // address, data and lanes go to every slave, strobes to one
  assign hk_bus.addr   = sys_addr_i;
  assign hk_bus.wdata  = sys_wdata_i;
  assign hk_bus.sel    = sys_sel_i;
  assign hk_bus.wen    = sys_wen_i && (req_region == `RP_REG_HK);
  assign hk_bus.ren    = sys_ren_i && (req_region == `RP_REG_HK);

  assign adc_bus.addr  = sys_addr_i;
  assign adc_bus.wdata = sys_wdata_i;
  assign adc_bus.sel   = sys_sel_i;
  assign adc_bus.wen   = sys_wen_i && (req_region == `RP_REG_ADC);
  assign adc_bus.ren   = sys_ren_i && (req_region == `RP_REG_ADC);

  assign dac_bus.addr  = sys_addr_i;
  assign dac_bus.wdata = sys_wdata_i;
  assign dac_bus.sel   = sys_sel_i;
  assign dac_bus.wen   = sys_wen_i && (req_region == `RP_REG_DAC);
  assign dac_bus.ren   = sys_ren_i && (req_region == `RP_REG_DAC);

  // region latch and default ack
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rsp_region <= '0;
      def_ack    <= 1'b0;
    end
    else
    begin
      if (strobe)
        rsp_region <= req_region;  // held until the next request
      def_ack <= strobe && unmapped; // empty regions answer in one cycle
    end
  end

  ////////////////////////////////////////////////////////////
  // response mux
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (rsp_region)
      `RP_REG_HK:
      begin
        sys_ack_o   = hk_bus.ack;
        sys_rdata_o = hk_bus.rdata;
      end
      `RP_REG_ADC:
      begin
        sys_ack_o   = adc_bus.ack;
        sys_rdata_o = adc_bus.rdata;
      end
      `RP_REG_DAC:
      begin
        sys_ack_o   = dac_bus.ack;
        sys_rdata_o = dac_bus.rdata;
      end
      default:
      begin
        sys_ack_o   = def_ack;     // empty regions read zero
        sys_rdata_o = '0;
      end
    endcase
  end

  // processor never reads and writes in the same cycle
  a_no_rw_overlap: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    !(sys_wen_i && sys_ren_i));

endmodule

`default_nettype wire

// File: source/housekeeping_regs.sv
// housekeeping registers
`timescale 1ns/1ps
`default_nettype none

`include "rp_cfg.svh"

module housekeeping_regs (
  input  wire           adc_clk,
  input  wire           arst_n_i,
  sys_bus_if.slave      bus,
  output rp_pkg::led_t  led_o,
  output logic          loop_en_o
);

  logic [`RP_REGION_LSB-1:0] ofs;  // offset inside region 0

  assign ofs = bus.addr[`RP_REGION_LSB-1:0];

  ////////////////////////////////////////////////////////////
  // configuration registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      led_o     <= '0;     // leds dark
      loop_en_o <= 1'b0;   // pins feed the adc path
    end
    else if (bus.wen && bus.sel[0])
    begin
      // all fields sit in byte lane 0
      case (ofs)
        `RP_HK_LOOP_OFS: loop_en_o <= bus.wdata[0];
        `RP_HK_LED_OFS:  led_o     <= bus.wdata[`RP_LED_BITS-1:0];
        default:         ;    // id and holes are read only
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // bus response
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      bus.ack   <= 1'b0;
      bus.rdata <= '0;
    end
    else
    begin
      bus.ack   <= bus.wen || bus.ren;
      bus.rdata <= '0;                 // writes return zero
      if (bus.ren)
      begin
        case (ofs)
          `RP_HK_ID_OFS:   bus.rdata <= `RP_HK_ID;
          `RP_HK_LOOP_OFS: bus.rdata <= {{(`RP_BUS_BITS-1){1'b0}}, loop_en_o};
          `RP_HK_LED_OFS:  bus.rdata <= {{(`RP_BUS_BITS-`RP_LED_BITS){1'b0}}, led_o};
          default:         bus.rdata <= '0;
        endcase
      end
    end
  end

  // one cycle ack, and no back to back request from the decoder
  a_hk_ack: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    (bus.wen || bus.ren) |=> bus.ack ##1 !bus.ack);

endmodule

`default_nettype wire

// File: source/analog_frontend.sv
// adc capture and readback
`timescale 1ns/1ps
`default_nettype none

`include "rp_cfg.svh"

module analog_frontend (
  input  wire              adc_clk,
  input  wire              arst_n_i,
  input  rp_pkg::adc_raw_t adc_dat_a_i,
  input  rp_pkg::adc_raw_t adc_dat_b_i,
  input  wire              loop_en_i,
  input  rp_pkg::sample_t  dac_a_i,
  input  rp_pkg::sample_t  dac_b_i,
  sys_bus_if.slave         bus
);

  rp_pkg::adc_raw_t adc_raw_a;  // pin registers
  rp_pkg::adc_raw_t adc_raw_b;
  rp_pkg::sample_t  smp_a;      // converted or looped samples
  rp_pkg::sample_t  smp_b;

  // io registers, then neg slope offset binary to two's complement
  always_ff @(posedge adc_clk)
  begin
    adc_raw_a <= adc_dat_a_i;
    adc_raw_b <= adc_dat_b_i;
    smp_a <= loop_en_i ? dac_a_i : {adc_raw_a[`RP_ADC_BITS-1], ~adc_raw_a[`RP_ADC_BITS-2:0]};
    smp_b <= loop_en_i ? dac_b_i : {adc_raw_b[`RP_ADC_BITS-1], ~adc_raw_b[`RP_ADC_BITS-2:0]};
  end

  ////////////////////////////////////////////////////////////
  // region 1 readback
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      bus.ack   <= 1'b0;
      bus.rdata <= '0;
    end
    else
    begin
      bus.ack   <= bus.wen || bus.ren;   // writes are acked and dropped
      bus.rdata <= '0;
      if (bus.ren)
      begin
        case (bus.addr[`RP_REGION_LSB-1:0])
          `RP_ADC_A_OFS: bus.rdata <= {{(`RP_BUS_BITS-`RP_ADC_BITS){smp_a[`RP_ADC_BITS-1]}},
                                       smp_a};
          `RP_ADC_B_OFS: bus.rdata <= {{(`RP_BUS_BITS-`RP_ADC_BITS){smp_b[`RP_ADC_BITS-1]}},
                                       smp_b};
          default:       bus.rdata <= '0;
        endcase
      end
    end
  end

  a_adc_ack: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    (bus.wen || bus.ren) |=> bus.ack ##1 !bus.ack);

endmodule

`default_nettype wire

// File: source/dac_output.sv
// dac level registers and pin stage
`timescale 1ns/1ps
`default_nettype none

`include "rp_cfg.svh"

module dac_output (
  input  wire               adc_clk,
  input  wire               arst_n_i,
  sys_bus_if.slave          bus,
  output rp_pkg::sample_t   dac_a_o,
  output rp_pkg::sample_t   dac_b_o,
  output rp_pkg::adc_raw_t  dac_dat_a_o,
  output rp_pkg::adc_raw_t  dac_dat_b_o
);

  logic [`RP_REGION_LSB-1:0] ofs;
  logic                      lvl_wr;  // needs both low lanes

  assign ofs    = bus.addr[`RP_REGION_LSB-1:0];
  assign lvl_wr = bus.wen && (bus.sel[1:0] == 2'b11);

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_a_o     <= '0;
      dac_b_o     <= '0;
      dac_dat_a_o <= {1'b0, {(`RP_ADC_BITS-1){1'b1}}};  // mid scale
      dac_dat_b_o <= {1'b0, {(`RP_ADC_BITS-1){1'b1}}};
      bus.ack     <= 1'b0;
      bus.rdata   <= '0;
    end
    else
    begin
      if (lvl_wr && (ofs == `RP_DAC_A_OFS))
        dac_a_o <= bus.wdata[`RP_ADC_BITS-1:0];
      if (lvl_wr && (ofs == `RP_DAC_B_OFS))
        dac_b_o <= bus.wdata[`RP_ADC_BITS-1:0];
      // pin registers, signed back to neg slope offset binary
      dac_dat_a_o <= {dac_a_o[`RP_ADC_BITS-1], ~dac_a_o[`RP_ADC_BITS-2:0]};
      dac_dat_b_o <= {dac_b_o[`RP_ADC_BITS-1], ~dac_b_o[`RP_ADC_BITS-2:0]};
      // levels read back sign extended
      bus.ack   <= bus.wen || bus.ren;
      bus.rdata <= '0;
      if (bus.ren && (ofs == `RP_DAC_A_OFS))
        bus.rdata <= {{(`RP_BUS_BITS-`RP_ADC_BITS){dac_a_o[`RP_ADC_BITS-1]}}, dac_a_o};
      if (bus.ren && (ofs == `RP_DAC_B_OFS))
        bus.rdata <= {{(`RP_BUS_BITS-`RP_ADC_BITS){dac_b_o[`RP_ADC_BITS-1]}}, dac_b_o};
    end
  end

  a_dac_ack: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    (bus.wen || bus.ren) |=> bus.ack ##1 !bus.ack);

endmodule

`default_nettype wire

// File: source/rp_top.sv
// analog board top level
`timescale 1ns/1ps
`default_nettype none

module rp_top (
  input  wire               adc_clk,
  input  wire               arst_n_i,
  input  rp_pkg::adc_raw_t  adc_dat_a_i,   // adc ch1 pins
  input  rp_pkg::adc_raw_t  adc_dat_b_i,   // adc ch2 pins
  input  rp_pkg::bus_addr_t sys_addr_i,
  input  rp_pkg::bus_data_t sys_wdata_i,
  input  rp_pkg::bus_sel_t  sys_sel_i,
  input  wire               sys_wen_i,
  input  wire               sys_ren_i,
  output rp_pkg::bus_data_t sys_rdata_o,
  output wire               sys_ack_o,
  output rp_pkg::adc_raw_t  dac_dat_a_o,   // dac ch1 pins
  output rp_pkg::adc_raw_t  dac_dat_b_o,   // dac ch2 pins
  output rp_pkg::led_t      led_o
);

  wire             loop_en;    // digital loopback switch
  rp_pkg::sample_t dac_a;      // software dac levels
  rp_pkg::sample_t dac_b;

  sys_bus_if hk_bus  ();       // region 0
  sys_bus_if adc_bus ();       // region 1
  sys_bus_if dac_bus ();       // region 3

  ////////////////////////////////////////////////////////////
  // decode, execute and result stages
  ////////////////////////////////////////////////////////////

  sys_bus_decode u_decode (
    .adc_clk (adc_clk), .arst_n_i (arst_n_i),
    .sys_addr_i (sys_addr_i), .sys_wdata_i (sys_wdata_i), .sys_sel_i (sys_sel_i),
    .sys_wen_i (sys_wen_i), .sys_ren_i (sys_ren_i),
    .sys_rdata_o (sys_rdata_o), .sys_ack_o (sys_ack_o),
    .hk_bus (hk_bus.master), .adc_bus (adc_bus.master), .dac_bus (dac_bus.master)
  );

  housekeeping_regs u_hk (
    .adc_clk (adc_clk), .arst_n_i (arst_n_i), .bus (hk_bus.slave),
    .led_o (led_o), .loop_en_o (loop_en)
  );

  analog_frontend u_adc (
    .adc_clk (adc_clk), .arst_n_i (arst_n_i),
    .adc_dat_a_i (adc_dat_a_i), .adc_dat_b_i (adc_dat_b_i),
    .loop_en_i (loop_en), .dac_a_i (dac_a), .dac_b_i (dac_b), .bus (adc_bus.slave)
  );

  dac_output u_dac (
    .adc_clk (adc_clk), .arst_n_i (arst_n_i), .bus (dac_bus.slave),
    .dac_a_o (dac_a), .dac_b_o (dac_b),
    .dac_dat_a_o (dac_dat_a_o), .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

`default_nettype wire

// File: sim/tb_rp_top.sv
// analog top level testbench
`timescale 1ns/1ps
`default_nettype none

`include "rp_cfg.svh"

module tb_rp_top;

  localparam integer N_ITER  = 16;                    // loops per behavior
  localparam integer N_OPS   = N_ITER * 20;           // bus ops and adc holds with headroom
  localparam integer WDOG_CY = N_OPS * 4 + 8 + 100;   // 4 cycles per op, reset, margin

  logic              adc_clk;
  logic              arst_n_i;
  rp_pkg::adc_raw_t  adc_dat_a_i;
  rp_pkg::adc_raw_t  adc_dat_b_i;
  rp_pkg::bus_addr_t sys_addr_i;
  rp_pkg::bus_data_t sys_wdata_i;
  rp_pkg::bus_sel_t  sys_sel_i;
  logic              sys_wen_i;
  logic              sys_ren_i;
  rp_pkg::bus_data_t sys_rdata_o;
  wire               sys_ack_o;
  rp_pkg::adc_raw_t  dac_dat_a_o;
  rp_pkg::adc_raw_t  dac_dat_b_o;
  rp_pkg::led_t      led_o;

  integer            seed   = 32'h28fe;
  integer            errors = 0;
  rp_pkg::led_t      led_m;     // reference model state
  logic              loop_m;
  rp_pkg::sample_t   dac_a_m;
  rp_pkg::sample_t   dac_b_m;
  rp_pkg::region_t   empty_regions [5] = '{3'd2, 3'd4, 3'd5, 3'd6, 3'd7};

  rp_top DUT (
    .adc_clk (adc_clk), .arst_n_i (arst_n_i),
    .adc_dat_a_i (adc_dat_a_i), .adc_dat_b_i (adc_dat_b_i),
    .sys_addr_i (sys_addr_i), .sys_wdata_i (sys_wdata_i), .sys_sel_i (sys_sel_i),
    .sys_wen_i (sys_wen_i), .sys_ren_i (sys_ren_i),
    .sys_rdata_o (sys_rdata_o), .sys_ack_o (sys_ack_o),
    .dac_dat_a_o (dac_dat_a_o), .dac_dat_b_o (dac_dat_b_o), .led_o (led_o)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;   // 100 ns period
  end

  initial
  begin
    #(WDOG_CY * 100);
    $display("timeout: the bus operations did not finish within %0d cycles", WDOG_CY);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////
  // model helpers
  ////////////////////////////////////////////////////////////

  // neg slope offset binary <-> two's complement in both directions
  function automatic logic [`RP_ADC_BITS-1:0] flip_low_bits(input logic [`RP_ADC_BITS-1:0] v);
    return {v[`RP_ADC_BITS-1], ~v[`RP_ADC_BITS-2:0]};
  endfunction

  function automatic rp_pkg::bus_data_t sext(input rp_pkg::sample_t s);
    return {{(`RP_BUS_BITS-`RP_ADC_BITS){s[`RP_ADC_BITS-1]}}, s};
  endfunction

  function automatic rp_pkg::bus_addr_t make_addr(input rp_pkg::region_t r,
                                                  input logic [19:0] ofs);
    return {{(`RP_BUS_BITS-`RP_REGION_MSB-1){1'b0}}, r, ofs};
  endfunction

  task automatic compare_values(input rp_pkg::bus_data_t act, input rp_pkg::bus_data_t exp,
                                input string what);
    if (act !== exp)
    begin
      errors++;
      $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, act, exp);
      $display("Verification failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus transactions
  ////////////////////////////////////////////////////////////

  // called 1 ns after the strobe edge and returns one idle cycle later
  task automatic wait_ack(output rp_pkg::bus_data_t rdata);
    integer waited;
    waited = 0;
    while (!sys_ack_o && waited < 4)
    begin
      @(posedge adc_clk);
      #1;
      waited++;
    end
    if (!sys_ack_o)
    begin
      $display("no bus acknowledge within 4 cycles at %0t ns", $time);
      $display("Verification failed");
      $fatal(1, "bus hang");
    end
    compare_values(waited, 0, "ack latency");   // fixed one cycle
    rdata = sys_rdata_o;
    @(posedge adc_clk);                         // no strobe in the ack cycle
    #1;
    compare_values(sys_ack_o, 1'b0, "ack wider than one cycle");
  endtask

  task automatic bus_write(input rp_pkg::bus_addr_t addr, input rp_pkg::bus_data_t data,
                           input rp_pkg::bus_sel_t sel);
    rp_pkg::bus_data_t rd;
    sys_addr_i  = addr;
    sys_wdata_i = data;
    sys_sel_i   = sel;
    sys_wen_i   = 1'b1;
    @(posedge adc_clk);
    #1;
    sys_wen_i = 1'b0;
    wait_ack(rd);
    compare_values(rd, '0, "write rdata");
  endtask

  task automatic bus_read(input rp_pkg::bus_addr_t addr, output rp_pkg::bus_data_t data);
    sys_addr_i = addr;
    sys_sel_i  = '1;
    sys_ren_i  = 1'b1;
    @(posedge adc_clk);
    #1;
    sys_ren_i = 1'b0;
    wait_ack(data);
  endtask

  // pins held 3 cycles, then both channels read back
  task automatic check_adc(input rp_pkg::adc_raw_t pin_a, input rp_pkg::adc_raw_t pin_b);
    rp_pkg::bus_data_t rd;
    adc_dat_a_i = pin_a;
    adc_dat_b_i = pin_b;
    repeat (3) @(posedge adc_clk);
    #1;
    bus_read(make_addr(`RP_REG_ADC, `RP_ADC_A_OFS), rd);
    compare_values(rd, loop_m ? sext(dac_a_m) : sext(flip_low_bits(pin_a)), "adc a sample");
    bus_read(make_addr(`RP_REG_ADC, `RP_ADC_B_OFS), rd);
    compare_values(rd, loop_m ? sext(dac_b_m) : sext(flip_low_bits(pin_b)), "adc b sample");
  endtask

  task automatic write_dac_levels();
    rp_pkg::bus_data_t wdat;
    rp_pkg::bus_data_t rd;
    wdat    = $random(seed);                    // upper bits are don't care
    dac_a_m = wdat[`RP_ADC_BITS-1:0];
    bus_write(make_addr(`RP_REG_DAC, `RP_DAC_A_OFS), wdat, 4'b0011);
    wdat    = $random(seed);
    dac_b_m = wdat[`RP_ADC_BITS-1:0];
    bus_write(make_addr(`RP_REG_DAC, `RP_DAC_B_OFS), wdat, 4'b0011);
    compare_values(dac_dat_a_o, flip_low_bits(dac_a_m), "dac a pins");
    compare_values(dac_dat_b_o, flip_low_bits(dac_b_m), "dac b pins");
    bus_read(make_addr(`RP_REG_DAC, `RP_DAC_A_OFS), rd);
    compare_values(rd, sext(dac_a_m), "dac a readback");
    bus_read(make_addr(`RP_REG_DAC, `RP_DAC_B_OFS), rd);
    compare_values(rd, sext(dac_b_m), "dac b readback");
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    rp_pkg::bus_data_t rd;
    rp_pkg::bus_data_t wdat;
    rp_pkg::bus_sel_t  sel;
    rp_pkg::region_t   r;
    integer            i;
    arst_n_i    = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_sel_i   = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    led_m       = '0;
    loop_m      = 1'b0;
    dac_a_m     = '0;
    dac_b_m     = '0;
    repeat (8) @(posedge adc_clk);
    #1;
    arst_n_i = 1'b1;
    compare_values(sys_ack_o, 1'b0, "ack after reset");
    compare_values(led_o, '0, "leds after reset");
    compare_values(dac_dat_a_o, 14'h1FFF, "dac a pins after reset");   // zero level
    compare_values(dac_dat_b_o, 14'h1FFF, "dac b pins after reset");
    // housekeeping id, led writes and lane 0 gating
    bus_read(make_addr(`RP_REG_HK, `RP_HK_ID_OFS), rd);
    compare_values(rd, `RP_HK_ID, "id word");
    for (i = 0; i < N_ITER; i++)
    begin
      wdat  = $random(seed);
      sel   = $random(seed);
      led_m = wdat[`RP_LED_BITS-1:0];
      bus_write(make_addr(`RP_REG_HK, `RP_HK_LED_OFS), wdat, sel | 4'b0001);
      compare_values(led_o, led_m, "led pins");
      bus_read(make_addr(`RP_REG_HK, `RP_HK_LED_OFS), rd);
      compare_values(rd, led_m, "led readback");
      wdat = $random(seed);
      sel  = $random(seed);
      bus_write(make_addr(`RP_REG_HK, `RP_HK_LED_OFS), wdat, sel & 4'b1110);  // ignored
      compare_values(led_o, led_m, "led after lane 0 clear write");
    end
    for (i = 0; i < N_ITER; i++)
      check_adc($random(seed), $random(seed));
    for (i = 0; i < N_ITER; i++)
      write_dac_levels();
    // with loopback on the pins must not matter
    loop_m = 1'b1;
    bus_write(make_addr(`RP_REG_HK, `RP_HK_LOOP_OFS), 32'h1, 4'b0001);
    bus_read(make_addr(`RP_REG_HK, `RP_HK_LOOP_OFS), rd);
    compare_values(rd, 32'h1, "loop bit readback");
    for (i = 0; i < N_ITER / 2; i++)
    begin
      write_dac_levels();
      check_adc($random(seed), $random(seed));
    end
    loop_m = 1'b0;
    bus_write(make_addr(`RP_REG_HK, `RP_HK_LOOP_OFS), 32'h0, 4'b0001);
    for (i = 0; i < N_ITER / 2; i++)
      check_adc($random(seed), $random(seed));
    // empty regions answer with zero and touch nothing
    for (i = 0; i < N_ITER; i++)
    begin
      r    = empty_regions[$unsigned($random(seed)) % 5];
      wdat = $random(seed);
      // offsets that land on real registers in the mapped regions
      if (wdat[31])
        bus_write(make_addr(r, $random(seed) & 20'h34), $random(seed), 4'b1111);
      else
      begin
        bus_read(make_addr(r, $random(seed) & 20'h34), rd);
        compare_values(rd, '0, "empty region rdata");
      end
      compare_values(led_o, led_m, "leds after empty region access");
      compare_values(dac_dat_a_o, flip_low_bits(dac_a_m), "dac a after empty region access");
      compare_values(dac_dat_b_o, flip_low_bits(dac_b_m), "dac b after empty region access");
      bus_read(make_addr(`RP_REG_HK, `RP_HK_LOOP_OFS), rd);
      compare_values(rd, loop_m, "loop bit after empty region access");
    end
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+source
source/rp_pkg.sv
source/sys_bus_if.sv
source/sys_bus_decode.sv
source/housekeeping_regs.sv
source/analog_frontend.sv
source/dac_output.sv
source/rp_top.sv
sim/tb_rp_top.sv
